//--- hw/ip_proto_pkg.sv
// Ethernet and IPv4 protocol definitions
// field types and fixed header constants shared by the framer
package ip_proto_pkg;

    // ethernet header fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;

    // ipv4 header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [5:0]  dscp_t;
    typedef logic [1:0]  ecn_t;
    typedef logic [2:0]  ip_flags_t;
    typedef logic [12:0] frag_off_t;

    // one byte of the data stream
    typedef logic [7:0] byte_t;

    // ones-complement sum of the header words, with room for carries
    typedef logic [19:0] csum_acc_t;

    // no options, so the header is always five 32-bit words
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;
    localparam ip_len_t IP_HDR_BYTES = 16'd20;

endpackage

//--- hw/ip_tx_pkg.sv
// IPv4 framer internal types
package ip_tx_pkg;

    // framing controller states
    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_WRITE_HEADER,
        STATE_WRITE_PAYLOAD,
        STATE_WRITE_PAYLOAD_LAST
    } tx_state_t;

    // position within the 20-byte header
    typedef logic [4:0] hdr_idx_t;

    localparam hdr_idx_t HDR_LAST_IDX = 5'd19;

endpackage

//--- hw/ip_hdr_regs.sv
`timescale 1ns/1ns
// IPv4 header field registers
// captures the header on accept and drives the Ethernet header output
module ip_hdr_regs (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      s_ip_hdr_valid,
    output logic                      s_ip_hdr_ready,
    input  ip_proto_pkg::mac_addr_t   s_eth_dest_mac,
    input  ip_proto_pkg::mac_addr_t   s_eth_src_mac,
    input  ip_proto_pkg::ether_type_t s_eth_type,
    input  ip_proto_pkg::dscp_t       s_ip_dscp,
    input  ip_proto_pkg::ecn_t        s_ip_ecn,
    input  ip_proto_pkg::ip_len_t     s_ip_length,
    input  logic [15:0]               s_ip_identification,
    input  ip_proto_pkg::ip_flags_t   s_ip_flags,
    input  ip_proto_pkg::frag_off_t   s_ip_fragment_offset,
    input  logic [7:0]                s_ip_ttl,
    input  logic [7:0]                s_ip_protocol,
    input  ip_proto_pkg::ip_addr_t    s_ip_source_ip,
    input  ip_proto_pkg::ip_addr_t    s_ip_dest_ip,

    input  logic                      ctrl_idle_next,
    output logic                      hdr_accept,

    output logic                      m_eth_hdr_valid,
    input  logic                      m_eth_hdr_ready,
    output ip_proto_pkg::mac_addr_t   m_eth_dest_mac,
    output ip_proto_pkg::mac_addr_t   m_eth_src_mac,
    output ip_proto_pkg::ether_type_t m_eth_type,

    output ip_proto_pkg::dscp_t       ip_dscp,
    output ip_proto_pkg::ecn_t        ip_ecn,
    output ip_proto_pkg::ip_len_t     ip_length,
    output logic [15:0]               ip_identification,
    output ip_proto_pkg::ip_flags_t   ip_flags,
    output ip_proto_pkg::frag_off_t   ip_fragment_offset,
    output logic [7:0]                ip_ttl,
    output logic [7:0]                ip_protocol,
    output ip_proto_pkg::ip_addr_t    ip_source_ip,
    output ip_proto_pkg::ip_addr_t    ip_dest_ip
);

    logic eth_valid_next;

    assign hdr_accept = s_ip_hdr_valid && s_ip_hdr_ready;

    // eth header stays valid until the sink takes it
    assign eth_valid_next = hdr_accept || (m_eth_hdr_valid && !m_eth_hdr_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            s_ip_hdr_ready <= 1'b0;
            m_eth_hdr_valid <= 1'b0;
        end else begin
            // open again once the frame is done and the eth header has drained
            s_ip_hdr_ready <= ctrl_idle_next && !eth_valid_next;
            m_eth_hdr_valid <= eth_valid_next;
        end

        if (hdr_accept) begin
            m_eth_dest_mac <= s_eth_dest_mac;
            m_eth_src_mac <= s_eth_src_mac;
            m_eth_type <= s_eth_type;
            ip_dscp <= s_ip_dscp;
            ip_ecn <= s_ip_ecn;
            ip_length <= s_ip_length;
            ip_identification <= s_ip_identification;
            ip_flags <= s_ip_flags;
            ip_fragment_offset <= s_ip_fragment_offset;
            ip_ttl <= s_ip_ttl;
            ip_protocol <= s_ip_protocol;
            ip_source_ip <= s_ip_source_ip;
            ip_dest_ip <= s_ip_dest_ip;
        end
    end

endmodule

//--- hw/ip_tx_ctrl.sv
`timescale 1ns/1ns
// IPv4 framing controller
// sends the header with its checksum, then the payload cut or flagged to ip_length
module ip_tx_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    hdr_accept,
    input  ip_proto_pkg::dscp_t     ip_dscp,
    input  ip_proto_pkg::ecn_t      ip_ecn,
    input  ip_proto_pkg::ip_len_t   ip_length,
    input  logic [15:0]             ip_identification,
    input  ip_proto_pkg::ip_flags_t ip_flags,
    input  ip_proto_pkg::frag_off_t ip_fragment_offset,
    input  logic [7:0]              ip_ttl,
    input  logic [7:0]              ip_protocol,
    input  ip_proto_pkg::ip_addr_t  ip_source_ip,
    input  ip_proto_pkg::ip_addr_t  ip_dest_ip,
    output logic                    ctrl_idle_next,

    input  ip_proto_pkg::byte_t     s_ip_payload_tdata,
    input  logic                    s_ip_payload_tvalid,
    output logic                    s_ip_payload_tready,
    input  logic                    s_ip_payload_tlast,
    input  logic                    s_ip_payload_tuser,

    output ip_proto_pkg::byte_t     in_data,
    output logic                    in_valid,
    output logic                    in_last,
    output logic                    in_user,
    input  logic                    in_ready,
    input  logic                    in_ready_early,

    output logic                    busy,
    output logic                    error_payload_early_termination
);

    ip_tx_pkg::tx_state_t    state, state_next;
    ip_tx_pkg::hdr_idx_t     hdr_idx, hdr_idx_next;
    ip_proto_pkg::ip_len_t   word_count, word_count_next;
    ip_proto_pkg::csum_acc_t hdr_sum, hdr_sum_next;
    ip_proto_pkg::byte_t     last_byte;
    ip_proto_pkg::byte_t     hdr_byte;
    logic                    store_last;
    logic                    tready_next;
    logic                    error_next;
    logic                    payload_xfer;

    // end-around carry
    function automatic ip_proto_pkg::csum_acc_t csum_fold(input ip_proto_pkg::csum_acc_t acc);
        csum_fold = {4'd0, acc[15:0]} + {16'd0, acc[19:16]};
    endfunction

    assign payload_xfer = s_ip_payload_tvalid && s_ip_payload_tready;
    assign ctrl_idle_next = (state_next == ip_tx_pkg::STATE_IDLE);

    // header bytes in network order
    always_comb begin
        case (hdr_idx)
            5'd0:    hdr_byte = {ip_proto_pkg::IP_VERSION, ip_proto_pkg::IP_IHL};
            5'd1:    hdr_byte = {ip_dscp, ip_ecn};
            5'd2:    hdr_byte = ip_length[15:8];
            5'd3:    hdr_byte = ip_length[7:0];
            5'd4:    hdr_byte = ip_identification[15:8];
            5'd5:    hdr_byte = ip_identification[7:0];
            5'd6:    hdr_byte = {ip_flags, ip_fragment_offset[12:8]};
            5'd7:    hdr_byte = ip_fragment_offset[7:0];
            5'd8:    hdr_byte = ip_ttl;
            5'd9:    hdr_byte = ip_protocol;
            5'd10:   hdr_byte = ~hdr_sum[15:8];
            5'd11:   hdr_byte = ~hdr_sum[7:0];
            5'd12:   hdr_byte = ip_source_ip[31:24];
            5'd13:   hdr_byte = ip_source_ip[23:16];
            5'd14:   hdr_byte = ip_source_ip[15:8];
            5'd15:   hdr_byte = ip_source_ip[7:0];
            5'd16:   hdr_byte = ip_dest_ip[31:24];
            5'd17:   hdr_byte = ip_dest_ip[23:16];
            5'd18:   hdr_byte = ip_dest_ip[15:8];
            default: hdr_byte = ip_dest_ip[7:0];
        endcase
    end

    always_comb begin
        state_next = state;
        hdr_idx_next = hdr_idx;
        word_count_next = word_count;
        hdr_sum_next = hdr_sum;
        tready_next = 1'b0;
        error_next = 1'b0;
        store_last = 1'b0;
        in_data = hdr_byte;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;

        case (state)
            ip_tx_pkg::STATE_IDLE: begin
                hdr_idx_next = '0;
                // byte 0 is constant, so it can go out with the accept
                in_data = {ip_proto_pkg::IP_VERSION, ip_proto_pkg::IP_IHL};
                if (hdr_accept) begin
                    state_next = ip_tx_pkg::STATE_WRITE_HEADER;
                    if (in_ready) begin
                        in_valid = 1'b1;
                        hdr_idx_next = 5'd1;
                    end
                end
            end
            ip_tx_pkg::STATE_WRITE_HEADER: begin
                word_count_next = ip_length - ip_proto_pkg::IP_HDR_BYTES;
                if (in_ready) begin
                    in_valid = 1'b1;
                    hdr_idx_next = hdr_idx + 5'd1;
                    // one header word per byte slot, done before byte 10 leaves
                    case (hdr_idx)
                        5'd1: hdr_sum_next = {4'd0, ip_proto_pkg::IP_VERSION,
                                              ip_proto_pkg::IP_IHL, ip_dscp, ip_ecn}
                                             + {4'd0, ip_length};
                        5'd2: hdr_sum_next = hdr_sum + {4'd0, ip_identification};
                        5'd3: hdr_sum_next = hdr_sum + {4'd0, ip_flags, ip_fragment_offset};
                        5'd4: hdr_sum_next = hdr_sum + {4'd0, ip_ttl, ip_protocol};
                        5'd5: hdr_sum_next = hdr_sum + {4'd0, ip_source_ip[31:16]};
                        5'd6: hdr_sum_next = hdr_sum + {4'd0, ip_source_ip[15:0]};
                        5'd7: hdr_sum_next = hdr_sum + {4'd0, ip_dest_ip[31:16]};
                        5'd8: hdr_sum_next = hdr_sum + {4'd0, ip_dest_ip[15:0]};
                        // two folds always bring nine words down to 16 bits
                        5'd9: hdr_sum_next = csum_fold(csum_fold(hdr_sum));
                        default: hdr_sum_next = hdr_sum;
                    endcase
                    if (hdr_idx == ip_tx_pkg::HDR_LAST_IDX) begin
                        tready_next = in_ready_early;
                        state_next = ip_tx_pkg::STATE_WRITE_PAYLOAD;
                    end
                end
            end
            ip_tx_pkg::STATE_WRITE_PAYLOAD: begin
                tready_next = in_ready_early;
                in_data = s_ip_payload_tdata;
                in_valid = payload_xfer;
                in_last = s_ip_payload_tlast;
                in_user = s_ip_payload_tuser;
                if (payload_xfer) begin
                    word_count_next = word_count - 16'd1;
                    if (s_ip_payload_tlast) begin
                        // input ended before the length ran out
                        if (word_count != 16'd1) begin
                            in_user = 1'b1;
                            error_next = 1'b1;
                        end
                        tready_next = 1'b0;
                        state_next = ip_tx_pkg::STATE_IDLE;
                    end else if (word_count == 16'd1) begin
                        store_last = 1'b1;
                        in_valid = 1'b0;
                        state_next = ip_tx_pkg::STATE_WRITE_PAYLOAD_LAST;
                    end
                end
            end
            default: begin
                // drop extra bytes, release the held one on tlast
                tready_next = in_ready_early;
                in_data = last_byte;
                in_valid = payload_xfer && s_ip_payload_tlast;
                in_last = 1'b1;
                in_user = s_ip_payload_tuser;
                if (payload_xfer && s_ip_payload_tlast) begin
                    tready_next = 1'b0;
                    state_next = ip_tx_pkg::STATE_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ip_tx_pkg::STATE_IDLE;
            hdr_idx <= '0;
            s_ip_payload_tready <= 1'b0;
            busy <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state <= state_next;
            hdr_idx <= hdr_idx_next;
            s_ip_payload_tready <= tready_next;
            busy <= (state_next != ip_tx_pkg::STATE_IDLE);
            error_payload_early_termination <= error_next;
        end

        word_count <= word_count_next;
        hdr_sum <= hdr_sum_next;
        if (store_last) begin
            last_byte <= s_ip_payload_tdata;
        end
    end

endmodule

//--- hw/axis_skid_buf.sv
`timescale 1ns/1ns
// byte stream output register with a temporary slot
// fully registered outputs, one byte per cycle while the sink is ready
module axis_skid_buf (
    input  logic                clk,
    input  logic                rst,

    input  ip_proto_pkg::byte_t in_data,
    input  logic                in_valid,
    input  logic                in_last,
    input  logic                in_user,
    output logic                in_ready,
    output logic                in_ready_early,

    output ip_proto_pkg::byte_t m_eth_payload_tdata,
    output logic                m_eth_payload_tvalid,
    input  logic                m_eth_payload_tready,
    output logic                m_eth_payload_tlast,
    output logic                m_eth_payload_tuser
);

    ip_proto_pkg::byte_t tmp_data;
    logic                tmp_valid, tmp_last, tmp_user;
    logic                out_valid_next, tmp_valid_next;
    logic                in_to_out, in_to_tmp, tmp_to_out;

    // stay ready unless the temp slot could fill next cycle
    assign in_ready_early = m_eth_payload_tready
                            || (!tmp_valid && (!m_eth_payload_tvalid || !in_valid));

    always_comb begin
        out_valid_next = m_eth_payload_tvalid;
        tmp_valid_next = tmp_valid;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;

        if (in_ready) begin
            if (m_eth_payload_tready || !m_eth_payload_tvalid) begin
                out_valid_next = in_valid;
                in_to_out = 1'b1;
            end else begin
                // sink stalled, park the byte
                tmp_valid_next = in_valid;
                in_to_tmp = 1'b1;
            end
        end else if (m_eth_payload_tready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_eth_payload_tvalid <= 1'b0;
            tmp_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            m_eth_payload_tvalid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
            in_ready <= in_ready_early;
        end

        if (in_to_out) begin
            m_eth_payload_tdata <= in_data;
            m_eth_payload_tlast <= in_last;
            m_eth_payload_tuser <= in_user;
        end else if (tmp_to_out) begin
            m_eth_payload_tdata <= tmp_data;
            m_eth_payload_tlast <= tmp_last;
            m_eth_payload_tuser <= tmp_user;
        end

        if (in_to_tmp) begin
            tmp_data <= in_data;
            tmp_last <= in_last;
            tmp_user <= in_user;
        end
    end

endmodule

//--- hw/ip_eth_tx.sv
`timescale 1ns/1ns
// IPv4 transmit framer top
// IP header fields plus payload in, Ethernet header and IPv4 byte stream out
module ip_eth_tx (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      s_ip_hdr_valid,
    output logic                      s_ip_hdr_ready,
    input  ip_proto_pkg::mac_addr_t   s_eth_dest_mac,
    input  ip_proto_pkg::mac_addr_t   s_eth_src_mac,
    input  ip_proto_pkg::ether_type_t s_eth_type,
    input  ip_proto_pkg::dscp_t       s_ip_dscp,
    input  ip_proto_pkg::ecn_t        s_ip_ecn,
    input  ip_proto_pkg::ip_len_t     s_ip_length,
    input  logic [15:0]               s_ip_identification,
    input  ip_proto_pkg::ip_flags_t   s_ip_flags,
    input  ip_proto_pkg::frag_off_t   s_ip_fragment_offset,
    input  logic [7:0]                s_ip_ttl,
    input  logic [7:0]                s_ip_protocol,
    input  ip_proto_pkg::ip_addr_t    s_ip_source_ip,
    input  ip_proto_pkg::ip_addr_t    s_ip_dest_ip,

    input  ip_proto_pkg::byte_t       s_ip_payload_tdata,
    input  logic                      s_ip_payload_tvalid,
    output logic                      s_ip_payload_tready,
    input  logic                      s_ip_payload_tlast,
    input  logic                      s_ip_payload_tuser,

    output logic                      m_eth_hdr_valid,
    input  logic                      m_eth_hdr_ready,
    output ip_proto_pkg::mac_addr_t   m_eth_dest_mac,
    output ip_proto_pkg::mac_addr_t   m_eth_src_mac,
    output ip_proto_pkg::ether_type_t m_eth_type,

    output ip_proto_pkg::byte_t       m_eth_payload_tdata,
    output logic                      m_eth_payload_tvalid,
    input  logic                      m_eth_payload_tready,
    output logic                      m_eth_payload_tlast,
    output logic                      m_eth_payload_tuser,

    output logic                      busy,
    output logic                      error_payload_early_termination
);

    // held header fields
    ip_proto_pkg::dscp_t     ip_dscp;
    ip_proto_pkg::ecn_t      ip_ecn;
    ip_proto_pkg::ip_len_t   ip_length;
    logic [15:0]             ip_identification;
    ip_proto_pkg::ip_flags_t ip_flags;
    ip_proto_pkg::frag_off_t ip_fragment_offset;
    logic [7:0]              ip_ttl;
    logic [7:0]              ip_protocol;
    ip_proto_pkg::ip_addr_t  ip_source_ip;
    ip_proto_pkg::ip_addr_t  ip_dest_ip;

    logic                    hdr_accept;
    logic                    ctrl_idle_next;

    // controller to output stage
    ip_proto_pkg::byte_t     in_data;
    logic                    in_valid, in_last, in_user;
    logic                    in_ready, in_ready_early;

    ip_hdr_regs u_hdr_regs (.*);

    ip_tx_ctrl u_ctrl (.*);

    axis_skid_buf u_out_buf (.*);

endmodule

//--- bench/ip_eth_tx_tb.sv
`timescale 1ns/1ns
// testbench for the IPv4 transmit framer
// random frames with exact, long and short payloads under output back-pressure
module ip_eth_tx_tb;

    localparam int NUM_FRAMES = 30;
    localparam int MAX_PAYLOAD = 40;
    localparam int MAX_EXTRA = 5;
    localparam int MAX_FRAME = 20 + MAX_PAYLOAD + MAX_EXTRA;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_FRAME + 20) * 4;
    // sink ready is low in this many cycles out of 4
    localparam int STALL_IN_4 = 1;

    integer seed = 44295;

    logic clk, rst;
    logic s_ip_hdr_valid, s_ip_hdr_ready;
    ip_proto_pkg::mac_addr_t s_eth_dest_mac, s_eth_src_mac, m_eth_dest_mac, m_eth_src_mac;
    ip_proto_pkg::ether_type_t s_eth_type, m_eth_type;
    ip_proto_pkg::dscp_t s_ip_dscp;
    ip_proto_pkg::ecn_t s_ip_ecn;
    ip_proto_pkg::ip_len_t s_ip_length;
    logic [15:0] s_ip_identification;
    ip_proto_pkg::ip_flags_t s_ip_flags;
    ip_proto_pkg::frag_off_t s_ip_fragment_offset;
    logic [7:0] s_ip_ttl, s_ip_protocol;
    ip_proto_pkg::ip_addr_t s_ip_source_ip, s_ip_dest_ip;
    ip_proto_pkg::byte_t s_ip_payload_tdata, m_eth_payload_tdata;
    logic s_ip_payload_tvalid, s_ip_payload_tready, s_ip_payload_tlast, s_ip_payload_tuser;
    logic m_eth_hdr_valid, m_eth_hdr_ready;
    logic m_eth_payload_tvalid, m_eth_payload_tready, m_eth_payload_tlast, m_eth_payload_tuser;
    logic busy, error_payload_early_termination;

    // expected output as {tuser, tlast, tdata}, expected eth header fields
    logic [9:0] exp_q[$];
    logic [111:0] eth_q[$];
    logic [9:0] exp_word;
    logic [111:0] eth_word;
    logic stream_ok, eth_ok;
    logic short_frame, in_frame, err_exp;
    int out_count = 0;

    ip_eth_tx uut (.*);

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        end_with_failure($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    function automatic int rand_range(input int n);
        rand_range = (($random(seed) % n) + n) % n;
    endfunction

    // 20 header bytes in network order, checksum folded until it fits 16 bits
    function automatic logic [159:0] header_model(
        input logic [5:0] dscp, input logic [1:0] ecn, input logic [15:0] len,
        input logic [15:0] id, input logic [2:0] flags, input logic [12:0] frag,
        input logic [7:0] ttl, input logic [7:0] proto, input logic [31:0] src,
        input logic [31:0] dst);
        logic [31:0] sum;
        sum = {16'd0, 4'd4, 4'd5, dscp, ecn} + {16'd0, len} + {16'd0, id}
              + {16'd0, flags, frag} + {16'd0, ttl, proto}
              + {16'd0, src[31:16]} + {16'd0, src[15:0]}
              + {16'd0, dst[31:16]} + {16'd0, dst[15:0]};
        while (sum[31:16] != 16'd0) begin
            sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        end
        header_model = {4'd4, 4'd5, dscp, ecn, len, id, flags, frag, ttl, proto,
                        ~sum[15:0], src, dst};
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random stalls on both output sinks
    initial begin
        m_eth_hdr_ready = 1'b0;
        m_eth_payload_tready = 1'b0;
        forever begin
            @(negedge clk);
            m_eth_hdr_ready = rand_range(4) >= STALL_IN_4;
            m_eth_payload_tready = rand_range(4) >= STALL_IN_4;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        end_with_failure("timeout: the frames did not all come out in time");
    end

    // frame window and expected error pulse, seen from the input side
    always @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            err_exp <= 1'b0;
        end else begin
            if (s_ip_hdr_valid && s_ip_hdr_ready) begin
                in_frame <= 1'b1;
            end else if (s_ip_payload_tvalid && s_ip_payload_tready && s_ip_payload_tlast) begin
                in_frame <= 1'b0;
            end
            err_exp <= s_ip_payload_tvalid && s_ip_payload_tready
                       && s_ip_payload_tlast && short_frame;
        end
    end

    always @(posedge clk) begin
        if (!rst && m_eth_payload_tvalid && m_eth_payload_tready) begin
            stream_ok = exp_q.size() != 0;
            if (stream_ok) begin
                exp_word = exp_q.pop_front();
            end
            out_count = out_count + 1;
            assert (stream_ok
                    && exp_word == {m_eth_payload_tuser, m_eth_payload_tlast, m_eth_payload_tdata})
                else report_mismatch($sformatf("output byte %0d {user,last,data} %h, expected %h",
                    out_count, {m_eth_payload_tuser, m_eth_payload_tlast, m_eth_payload_tdata},
                    exp_word));
        end
    end

    always @(posedge clk) begin
        if (!rst && m_eth_hdr_valid && m_eth_hdr_ready) begin
            eth_ok = eth_q.size() != 0;
            if (eth_ok) begin
                eth_word = eth_q.pop_front();
            end
            assert (eth_ok && eth_word == {m_eth_dest_mac, m_eth_src_mac, m_eth_type})
                else report_mismatch($sformatf("eth header %h, expected %h",
                    {m_eth_dest_mac, m_eth_src_mac, m_eth_type}, eth_word));
        end
    end

    assert property (@(posedge clk) $past(rst) |-> !(s_ip_hdr_ready || s_ip_payload_tready
        || m_eth_hdr_valid || m_eth_payload_tvalid || busy || error_payload_early_termination))
        else report_mismatch("valid, ready or status high after reset");
    assert property (@(posedge clk) disable iff (rst) !(s_ip_hdr_ready && busy))
        else report_mismatch("header ready high while busy");
    assert property (@(posedge clk) disable iff (rst) busy == in_frame)
        else report_mismatch("busy does not span header accept to input tlast");
    assert property (@(posedge clk) disable iff (rst) s_ip_payload_tready |-> busy)
        else report_mismatch("payload ready high outside a frame");
    assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination == err_exp)
        else report_mismatch("early termination pulse wrong");

    // kind 0 exact, 1 long, 2 short payload
    task automatic run_frame(input int kind);
        int plen, nin, nout;
        logic [159:0] hdr;
        ip_proto_pkg::byte_t pay [0:MAX_PAYLOAD + MAX_EXTRA - 1];
        int gap [0:MAX_PAYLOAD + MAX_EXTRA - 1];
        logic usr [0:MAX_PAYLOAD + MAX_EXTRA - 1];
        plen = 2 + rand_range(MAX_PAYLOAD - 1);
        nin = (kind == 1) ? plen + 1 + rand_range(MAX_EXTRA)
            : (kind == 2) ? 1 + rand_range(plen - 1) : plen;
        nout = (nin < plen) ? nin : plen;
        s_eth_dest_mac = {16'(rand_range(65536)), $random(seed)};
        s_eth_src_mac = {16'(rand_range(65536)), $random(seed)};
        s_eth_type = 16'(rand_range(65536));
        s_ip_dscp = 6'(rand_range(64));
        s_ip_ecn = 2'(rand_range(4));
        s_ip_length = 16'(plen + 20);
        s_ip_identification = 16'(rand_range(65536));
        s_ip_flags = 3'(rand_range(8));
        s_ip_fragment_offset = 13'(rand_range(8192));
        s_ip_ttl = 8'(rand_range(256));
        s_ip_protocol = 8'(rand_range(256));
        s_ip_source_ip = $random(seed);
        s_ip_dest_ip = $random(seed);
        hdr = header_model(s_ip_dscp, s_ip_ecn, s_ip_length, s_ip_identification, s_ip_flags,
                           s_ip_fragment_offset, s_ip_ttl, s_ip_protocol, s_ip_source_ip,
                           s_ip_dest_ip);
        for (int i = 0; i < 20; i++) begin
            exp_q.push_back({2'b00, hdr[159:152]});
            hdr = hdr << 8;
        end
        for (int i = 0; i < nin; i++) begin
            pay[i] = 8'(rand_range(256));
            gap[i] = (rand_range(4) == 0) ? 1 + rand_range(3) : 0;
            usr[i] = rand_range(2) == 1;
        end
        // a short frame always ends with tuser set
        // a cut frame ends with the tuser of the input tlast byte
        for (int i = 0; i < nout; i++) begin
            exp_q.push_back({(i == nout - 1) ? (kind == 2 || usr[nin - 1]) : usr[i],
                             i == nout - 1, pay[i]});
        end
        eth_q.push_back({s_eth_dest_mac, s_eth_src_mac, s_eth_type});
        short_frame = kind == 2;
        fork
            begin
                s_ip_hdr_valid = 1'b1;
                while (!s_ip_hdr_ready) @(negedge clk);
                @(negedge clk);
                s_ip_hdr_valid = 1'b0;
            end
            begin
                for (int i = 0; i < nin; i++) begin
                    s_ip_payload_tvalid = 1'b0;
                    repeat (gap[i]) @(negedge clk);
                    s_ip_payload_tdata = pay[i];
                    s_ip_payload_tlast = i == nin - 1;
                    s_ip_payload_tuser = usr[i];
                    s_ip_payload_tvalid = 1'b1;
                    while (!s_ip_payload_tready) @(negedge clk);
                    @(negedge clk);
                end
                s_ip_payload_tvalid = 1'b0;
                s_ip_payload_tlast = 1'b0;
                s_ip_payload_tuser = 1'b0;
            end
        join
    endtask

    initial begin
        rst = 1'b1;
        short_frame = 1'b0;
        s_ip_hdr_valid = 1'b0;
        s_eth_dest_mac = '0;
        s_eth_src_mac = '0;
        s_eth_type = '0;
        s_ip_dscp = '0;
        s_ip_ecn = '0;
        s_ip_length = '0;
        s_ip_identification = '0;
        s_ip_flags = '0;
        s_ip_fragment_offset = '0;
        s_ip_ttl = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_ip_payload_tdata = '0;
        s_ip_payload_tvalid = 1'b0;
        s_ip_payload_tlast = 1'b0;
        s_ip_payload_tuser = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f % 3);
        end
        while (exp_q.size() != 0 || eth_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        if (m_eth_payload_tvalid || m_eth_hdr_valid || busy) begin
            report_mismatch($sformatf("output valid or busy after the last of %0d bytes",
                out_count));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- flist.f
hw/ip_proto_pkg.sv
hw/ip_tx_pkg.sv
hw/ip_hdr_regs.sv
hw/ip_tx_ctrl.sv
hw/axis_skid_buf.sv
hw/ip_eth_tx.sv
bench/ip_eth_tx_tb.sv

//--- run.sh
#!/bin/sh
# build and run the IPv4 framer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module ip_eth_tx_tb -o ip_eth_tx_tb
./obj_dir/ip_eth_tx_tb
